// ==== common/tlb_addr_pkg.sv ====
package tlb_addr_pkg;

  // Sv39 virtual tag is VPN[2:0], physical tag is PPN[2:0]
  localparam int vtag_width = 27;
  localparam int ptag_width = 28;

  // One level of the page table index
  localparam int page_idx_width = 9;

  // Tag bits below the gigapage level (VPN[1:0] / PPN[1:0])
  localparam int low_bits = 2 * page_idx_width;

  typedef logic [vtag_width-1:0] vtag_t;
  typedef logic [ptag_width-1:0] ptag_t;

endpackage

// ==== common/tlb_cfg_pkg.sv ====
package tlb_cfg_pkg;

  // Ways per store
  localparam int els_4k = 8;
  localparam int els_1g = 2;

  // Read, write, execute, user, global, accessed, dirty
  localparam int flag_width = 7;

  // Physical tag in the top bits, flags below
  localparam int entry_width = tlb_addr_pkg::ptag_width + flag_width;

  typedef logic [entry_width-1:0] entry_t;

  // Part of an entry that a gigapage keeps: top PPN bits plus flags
  localparam int high_width =
    tlb_addr_pkg::ptag_width - tlb_addr_pkg::low_bits + flag_width;

endpackage

// ==== common/tlb_lookup_if.sv ====
interface tlb_lookup_if;

  // Write side, one strobe per page size
  logic wr_4k;
  logic wr_1g;
  tlb_addr_pkg::vtag_t wr_vtag;

  // Rotated so that the flags sit above the physical tag
  tlb_cfg_pkg::entry_t wr_entry;

  // Read request, one cycle late
  logic rd_v_r;
  tlb_addr_pkg::vtag_t rd_vtag_r;

  modport decode (
    output wr_4k, wr_1g, wr_vtag, wr_entry, rd_v_r, rd_vtag_r
  );

  modport store (
    input wr_4k, wr_1g, wr_vtag, wr_entry, rd_v_r, rd_vtag_r
  );

endinterface

// ==== tlb_array/tlb_tag_cam.sv ====
module tlb_tag_cam #(
  parameter int els_p       = tlb_cfg_pkg::els_4k,
  parameter int tag_width_p = tlb_addr_pkg::vtag_width
) (
  input  logic                   clk_i,
  input  logic                   reset_i,
  input  logic [els_p-1:0]       set_i,
  input  logic                   clear_i,
  input  logic [tag_width_p-1:0] w_tag_i,
  input  logic [tag_width_p-1:0] r_tag_i,
  output logic [els_p-1:0]       match_o,
  output logic [els_p-1:0]       empty_o
);

  logic [els_p-1:0]                  valid_r;
  logic [els_p-1:0][tag_width_p-1:0] tag_r;

  // Clear beats a write in the same cycle
  always_ff @(posedge clk_i)
    begin
      if (reset_i || clear_i)
        valid_r <= '0;
      else
        valid_r <= valid_r | set_i;
    end

  always_ff @(posedge clk_i)
    begin
      for (int i = 0; i < els_p; i++)
        begin
          if (set_i[i])
            tag_r[i] <= w_tag_i;
        end
    end

  always_comb
    begin
      for (int i = 0; i < els_p; i++)
        match_o[i] = valid_r[i] && (tag_r[i] == r_tag_i);
    end

  assign empty_o = ~valid_r;

  // Replacement must hand over a single way
  assert property (@(posedge clk_i) disable iff (reset_i) $onehot0(set_i));

endmodule

// ==== tlb_array/tlb_repl.sv ====
module tlb_repl #(
  parameter int els_p = tlb_cfg_pkg::els_4k
) (
  input  logic             clk_i,
  input  logic             reset_i,
  input  logic             alloc_v_i,
  input  logic [els_p-1:0] empty_i,
  input  logic [els_p-1:0] touch_i,
  output logic [els_p-1:0] way_o
);

  localparam int lvl_lp = $clog2(els_p);

  // Heap ordered tree, a set bit means the victim lies to the right
  logic [els_p-2:0] lru_r;
  logic [els_p-2:0] lru_n;
  logic [els_p-1:0] lowest_empty;
  logic [els_p-1:0] plru_way;
  logic [els_p-1:0] used_way;

  assign lowest_empty = empty_i & (~empty_i + 1'b1);

  always_comb
    begin
      int node;
      node = 0;
      for (int l = 0; l < lvl_lp; l++)
        node = 2 * node + 1 + int'(lru_r[node]);
      plru_way = '0;
      plru_way[node - (els_p - 1)] = 1'b1;
    end

  assign way_o = (|empty_i) ? lowest_empty : plru_way;
  assign used_way = alloc_v_i ? way_o : touch_i;

  // Walk up from the used leaf and point every node the other way
  always_comb
    begin
      int leaf;
      int parent;
      lru_n = lru_r;
      leaf = 0;
      for (int i = 0; i < els_p; i++)
        begin
          if (used_way[i])
            leaf = i + els_p - 1;
        end
      for (int l = 0; l < lvl_lp; l++)
        begin
          parent = (leaf - 1) / 2;
          lru_n[parent] = (leaf == 2 * parent + 1);
          leaf = parent;
        end
    end

  always_ff @(posedge clk_i)
    begin
      if (reset_i)
        lru_r <= '0;
      else if (|used_way)
        lru_r <= lru_n;
    end

  assert property (@(posedge clk_i) disable iff (reset_i) alloc_v_i |-> $onehot(way_o));

endmodule

// ==== tlb_array/tlb_page_store.sv ====
module tlb_page_store #(
  parameter int els_p        = tlb_cfg_pkg::els_4k,
  parameter int tag_width_p  = tlb_addr_pkg::vtag_width,
  parameter int data_width_p = tlb_cfg_pkg::entry_width,
  parameter bit gigapage_p   = 1'b0
) (
  input  logic                                clk_i,
  input  logic                                reset_i,
  tlb_lookup_if.store                         lk,
  input  logic                                flush_i,
  output logic [els_p-1:0]                    match_o,
  output logic [els_p-1:0][data_width_p-1:0]  data_o
);

  localparam int vtag_lp  = tlb_addr_pkg::vtag_width;
  localparam int entry_lp = tlb_cfg_pkg::entry_width;

  logic                    wr_v;
  logic [els_p-1:0]        empty;
  logic [els_p-1:0]        repl_way;
  logic [els_p-1:0]        set_way;
  logic [tag_width_p-1:0]  w_tag;
  logic [tag_width_p-1:0]  r_tag;
  logic [data_width_p-1:0] w_data;

  assign wr_v = gigapage_p ? lk.wr_1g : lk.wr_4k;

  // Gigapages only compare VPN[2]
  assign w_tag  = lk.wr_vtag[vtag_lp-1 -: tag_width_p];
  assign r_tag  = lk.rd_vtag_r[vtag_lp-1 -: tag_width_p];
  assign w_data = lk.wr_entry[entry_lp-1 -: data_width_p];

  assign set_way = {els_p{wr_v}} & repl_way;

  tlb_tag_cam #(
    .els_p       (els_p),
    .tag_width_p (tag_width_p)
  ) cam (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .set_i   (set_way),
    .clear_i (flush_i),
    .w_tag_i (w_tag),
    .r_tag_i (r_tag),
    .match_o (match_o),
    .empty_o (empty)
  );

  tlb_repl #(
    .els_p (els_p)
  ) repl (
    .clk_i     (clk_i),
    .reset_i   (reset_i),
    .alloc_v_i (wr_v),
    .empty_i   (empty),
    .touch_i   (match_o & {els_p{lk.rd_v_r}}),
    .way_o     (repl_way)
  );

  always_ff @(posedge clk_i)
    begin
      for (int i = 0; i < els_p; i++)
        begin
          if (set_way[i])
            data_o[i] <= w_data;
        end
    end

endmodule

// ==== hw/tlb_req_decode.sv ====
module tlb_req_decode (
  input  logic                clk_i,
  input  logic                reset_i,
  input  logic                v_i,
  input  logic                w_i,
  input  logic                gigapage_i,
  input  tlb_addr_pkg::vtag_t vtag_i,
  input  tlb_cfg_pkg::entry_t entry_i,
  tlb_lookup_if.decode        lk
);

  localparam int flag_lp = tlb_cfg_pkg::flag_width;
  localparam int ptag_lp = tlb_addr_pkg::ptag_width;

  assign lk.wr_4k = v_i & w_i & ~gigapage_i;
  assign lk.wr_1g = v_i & w_i & gigapage_i;
  assign lk.wr_vtag = vtag_i;

  // Flags move to the top so a gigapage keeps one contiguous upper slice
  assign lk.wr_entry = {entry_i[flag_lp-1:0], entry_i[tlb_cfg_pkg::entry_width-1 -: ptag_lp]};

  always_ff @(posedge clk_i)
    begin
      if (reset_i)
        lk.rd_v_r <= 1'b0;
      else
        lk.rd_v_r <= v_i & ~w_i;
    end

  always_ff @(posedge clk_i)
    begin
      lk.rd_vtag_r <= vtag_i;
    end

endmodule

// ==== hw/tlb_entry_mux.sv ====
module tlb_entry_mux (
  input  logic                                                         rd_v_r_i,
  input  tlb_addr_pkg::vtag_t                                          rd_vtag_r_i,
  input  logic [tlb_cfg_pkg::els_4k-1:0]                               match_4k_i,
  input  logic [tlb_cfg_pkg::els_4k-1:0][tlb_cfg_pkg::entry_width-1:0] data_4k_i,
  input  logic [tlb_cfg_pkg::els_1g-1:0]                               match_1g_i,
  input  logic [tlb_cfg_pkg::els_1g-1:0][tlb_cfg_pkg::high_width-1:0]  data_1g_i,
  output logic                                                         v_o,
  output tlb_cfg_pkg::entry_t                                          entry_o,
  output logic                                                         multi_hit_o
);

  localparam int low_lp  = tlb_addr_pkg::low_bits;
  localparam int high_lp = tlb_cfg_pkg::high_width;
  localparam int flag_lp = tlb_cfg_pkg::flag_width;

  logic                hit_4k;
  logic                hit_1g;
  logic [high_lp-1:0]  high_sel;
  logic [low_lp-1:0]   low_sel;
  logic [flag_lp-1:0]  r_flags;
  tlb_addr_pkg::ptag_t r_ptag;

  assign hit_4k = |match_4k_i;
  assign hit_1g = |match_1g_i;

  // AND-OR selection, matches are one-hot within a store
  always_comb
    begin
      high_sel = '0;
      low_sel  = hit_1g ? rd_vtag_r_i[low_lp-1:0] : '0;
      for (int i = 0; i < tlb_cfg_pkg::els_4k; i++)
        begin
          if (match_4k_i[i])
            begin
              high_sel = high_sel | data_4k_i[i][tlb_cfg_pkg::entry_width-1 -: high_lp];
              low_sel  = low_sel | data_4k_i[i][low_lp-1:0];
            end
        end
      for (int i = 0; i < tlb_cfg_pkg::els_1g; i++)
        begin
          if (match_1g_i[i])
            high_sel = high_sel | data_1g_i[i];
        end
    end

  // Undo the rotation, ptag back on top
  assign r_flags = high_sel[high_lp-1 -: flag_lp];
  assign r_ptag  = {high_sel[high_lp-flag_lp-1:0], low_sel};
  assign entry_o = {r_ptag, r_flags};

  assign v_o         = rd_v_r_i & (hit_4k ^ hit_1g);
  assign multi_hit_o = rd_v_r_i & hit_4k & hit_1g;

  // Duplicate tags inside one store would blend entries
  always_comb
    begin
      if (rd_v_r_i)
        assert ($onehot0(match_4k_i) && $onehot0(match_1g_i));
    end

endmodule

// ==== hw/tlb_top.sv ====
module tlb_top (
  input  logic                clk_i,
  input  logic                reset_i,
  input  logic                flush_i,
  input  logic                v_i,
  input  logic                w_i,
  input  logic                gigapage_i,
  input  tlb_addr_pkg::vtag_t vtag_i,
  input  tlb_cfg_pkg::entry_t entry_i,
  output logic                v_o,
  output tlb_cfg_pkg::entry_t entry_o
);

  logic [tlb_cfg_pkg::els_4k-1:0]                               match_4k;
  logic [tlb_cfg_pkg::els_4k-1:0][tlb_cfg_pkg::entry_width-1:0] data_4k;
  logic [tlb_cfg_pkg::els_1g-1:0]                               match_1g;
  logic [tlb_cfg_pkg::els_1g-1:0][tlb_cfg_pkg::high_width-1:0]  data_1g;
  logic                                                         multi_hit;

  tlb_lookup_if lk ();

  tlb_req_decode decode (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .v_i        (v_i),
    .w_i        (w_i),
    .gigapage_i (gigapage_i),
    .vtag_i     (vtag_i),
    .entry_i    (entry_i),
    .lk         (lk.decode)
  );

  // A 4k page shadowed by a gigapage is dropped wholesale
  tlb_page_store #(
    .els_p        (tlb_cfg_pkg::els_4k),
    .tag_width_p  (tlb_addr_pkg::vtag_width),
    .data_width_p (tlb_cfg_pkg::entry_width),
    .gigapage_p   (1'b0)
  ) store_4k (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .lk      (lk.store),
    .flush_i (flush_i | multi_hit),
    .match_o (match_4k),
    .data_o  (data_4k)
  );

  tlb_page_store #(
    .els_p        (tlb_cfg_pkg::els_1g),
    .tag_width_p  (tlb_addr_pkg::page_idx_width),
    .data_width_p (tlb_cfg_pkg::high_width),
    .gigapage_p   (1'b1)
  ) store_1g (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .lk      (lk.store),
    .flush_i (flush_i),
    .match_o (match_1g),
    .data_o  (data_1g)
  );

  tlb_entry_mux mux (
    .rd_v_r_i    (lk.rd_v_r),
    .rd_vtag_r_i (lk.rd_vtag_r),
    .match_4k_i  (match_4k),
    .data_4k_i   (data_4k),
    .match_1g_i  (match_1g),
    .data_1g_i   (data_1g),
    .v_o         (v_o),
    .entry_o     (entry_o),
    .multi_hit_o (multi_hit)
  );

endmodule

// ==== testbench/tlb_tb.sv ====
module tlb_tb;

  localparam int max_cycles = 2000;
  localparam int rounds = 6;

  logic                clk_i = 1'b0;
  logic                reset_i;
  logic                flush_i;
  logic                v_i;
  logic                w_i;
  logic                gigapage_i;
  tlb_addr_pkg::vtag_t vtag_i;
  tlb_cfg_pkg::entry_t entry_i;
  logic                v_o;
  tlb_cfg_pkg::entry_t entry_o;

  // Expectation for the read driven in this cycle, then one cycle later
  logic                req_chk;
  logic                req_known;
  logic                req_v;
  tlb_cfg_pkg::entry_t req_entry;
  logic                chk_r;
  logic                known_r;
  logic                exp_v_r;
  tlb_cfg_pkg::entry_t exp_entry_r;

  // Reference model, one list per page size
  tlb_addr_pkg::vtag_t model_4k_tag[$];
  tlb_cfg_pkg::entry_t model_4k_entry[$];
  bit                  model_4k_sure[$];
  logic [tlb_addr_pkg::page_idx_width-1:0] model_1g_vpn[$];
  tlb_cfg_pkg::entry_t model_1g_entry[$];
  tlb_addr_pkg::vtag_t written_tags[$];

  bit   counting;
  int   hit_count;
  logic count_chk;
  int   count_exp;
  int   cycle_count = 0;

  tlb_top dut0 (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .flush_i    (flush_i),
    .v_i        (v_i),
    .w_i        (w_i),
    .gigapage_i (gigapage_i),
    .vtag_i     (vtag_i),
    .entry_i    (entry_i),
    .v_o        (v_o),
    .entry_o    (entry_o)
  );

  always #50 clk_i = ~clk_i;

  always @(posedge clk_i)
    begin
      if (reset_i)
        chk_r <= 1'b0;
      else
        chk_r <= req_chk;
      known_r     <= req_known;
      exp_v_r     <= req_v;
      exp_entry_r <= req_entry;
    end

  always @(posedge clk_i)
    begin
      cycle_count = cycle_count + 1;
      if (cycle_count > max_cycles)
        begin
          $display("Timeout: the run did not finish within %0d cycles", max_cycles);
          $display("Some tests failed");
          $fatal(1, "Run stopped by the cycle limit");
        end
    end

  task automatic report_mismatch(input string name, input logic [63:0] got,
                                 input logic [63:0] expected);
    $display("Fail at time %0t: %s is %0h, expected %0h", $time, name, got, expected);
    $display("Some tests failed");
    $fatal(1, "Stopping at the first mismatch");
  endtask

  // No result outside a read
  assert property (@(posedge clk_i) disable iff (reset_i) !chk_r |-> !v_o)
    else report_mismatch("v_o", 64'($sampled(v_o)), 64'(0));

  assert property (@(posedge clk_i) disable iff (reset_i) (chk_r && known_r) |-> v_o == exp_v_r)
    else report_mismatch("v_o", 64'($sampled(v_o)), 64'($sampled(exp_v_r)));

  // An unsure tag may miss, but a hit must carry its entry
  assert property (@(posedge clk_i) disable iff (reset_i)
                   (chk_r && v_o && (exp_v_r || !known_r)) |-> entry_o == exp_entry_r)
    else report_mismatch("entry_o", 64'($sampled(entry_o)), 64'($sampled(exp_entry_r)));

  assert property (@(posedge clk_i) disable iff (reset_i) count_chk |-> hit_count == count_exp)
    else report_mismatch("hit_count", 64'($sampled(hit_count)), 64'($sampled(count_exp)));

  function automatic tlb_cfg_pkg::entry_t rand_entry();
    logic [63:0] r;
    r = {$urandom, $urandom};
    return r[tlb_cfg_pkg::entry_width-1:0];
  endfunction

  function automatic logic [tlb_addr_pkg::low_bits-1:0] rand_low();
    logic [31:0] r;
    r = $urandom;
    return r[tlb_addr_pkg::low_bits-1:0];
  endfunction

  // Gigapage regions keep the top tag bit set, 4k pages keep it clear
  function automatic logic [tlb_addr_pkg::page_idx_width-1:0] rand_giga_vpn();
    logic [31:0] r;
    r = $urandom;
    return {1'b1, r[tlb_addr_pkg::page_idx_width-2:0]};
  endfunction

  function automatic tlb_addr_pkg::vtag_t fresh_4k_tag();
    tlb_addr_pkg::vtag_t t;
    bit taken;
    taken = 1'b1;
    while (taken)
      begin
        t = tlb_addr_pkg::vtag_t'($urandom);
        t[tlb_addr_pkg::vtag_width-1] = 1'b0;
        taken = 1'b0;
        foreach (model_4k_tag[i])
          if (model_4k_tag[i] == t)
            taken = 1'b1;
      end
    return t;
  endfunction

  task automatic idle_cycle();
    v_i       = 1'b0;
    w_i       = 1'b0;
    flush_i   = 1'b0;
    req_chk   = 1'b0;
    count_chk = 1'b0;
    @(negedge clk_i);
  endtask

  task automatic flush_stores();
    v_i     = 1'b0;
    w_i     = 1'b0;
    flush_i = 1'b1;
    req_chk = 1'b0;
    model_4k_tag.delete();
    model_4k_entry.delete();
    model_4k_sure.delete();
    model_1g_vpn.delete();
    model_1g_entry.delete();
    @(negedge clk_i);
    flush_i = 1'b0;
  endtask

  task automatic write_page(input tlb_addr_pkg::vtag_t t, input tlb_cfg_pkg::entry_t e,
                            input bit giga);
    v_i        = 1'b1;
    w_i        = 1'b1;
    gigapage_i = giga;
    flush_i    = 1'b0;
    vtag_i     = t;
    entry_i    = e;
    req_chk    = 1'b0;
    if (giga)
      begin
        model_1g_vpn.push_back(t[tlb_addr_pkg::vtag_width-1 -: tlb_addr_pkg::page_idx_width]);
        model_1g_entry.push_back(e);
      end
    else
      begin
        // Store full, so the evicted way is no longer known
        if (model_4k_tag.size() >= tlb_cfg_pkg::els_4k)
          foreach (model_4k_sure[i])
            model_4k_sure[i] = 1'b0;
        model_4k_tag.push_back(t);
        model_4k_entry.push_back(e);
        model_4k_sure.push_back(1'b1);
      end
    @(negedge clk_i);
  endtask

  task automatic read_tag(input tlb_addr_pkg::vtag_t t);
    logic                hit_4k;
    logic                hit_1g;
    logic                sure;
    tlb_cfg_pkg::entry_t e_4k;
    tlb_cfg_pkg::entry_t e_1g;
    tlb_cfg_pkg::entry_t g;
    hit_4k = 1'b0;
    hit_1g = 1'b0;
    sure   = 1'b1;
    e_4k   = '0;
    e_1g   = '0;
    foreach (model_4k_tag[i])
      if (model_4k_tag[i] == t)
        begin
          hit_4k = 1'b1;
          sure   = model_4k_sure[i];
          e_4k   = model_4k_entry[i];
        end
    foreach (model_1g_vpn[i])
      if (model_1g_vpn[i] == t[tlb_addr_pkg::vtag_width-1 -: tlb_addr_pkg::page_idx_width])
        begin
          hit_1g = 1'b1;
          g      = model_1g_entry[i];
          e_1g   = {g[tlb_cfg_pkg::entry_width-1 -: 10], t[tlb_addr_pkg::low_bits-1:0],
                    g[tlb_cfg_pkg::flag_width-1:0]};
        end
    v_i        = 1'b1;
    w_i        = 1'b0;
    gigapage_i = 1'b0;
    flush_i    = 1'b0;
    vtag_i     = t;
    req_chk    = 1'b1;
    req_known  = sure;
    req_v      = hit_4k ^ hit_1g;
    req_entry  = hit_1g ? e_1g : e_4k;
    // A hit in both stores drops every 4k page
    if (hit_4k && hit_1g)
      begin
        model_4k_tag.delete();
        model_4k_entry.delete();
        model_4k_sure.delete();
      end
    @(negedge clk_i);
    if (counting && v_o)
      hit_count++;
  endtask

  task automatic check_hit_count(input int expected);
    v_i       = 1'b0;
    req_chk   = 1'b0;
    count_exp = expected;
    count_chk = 1'b1;
    @(negedge clk_i);
    count_chk = 1'b0;
  endtask

  task automatic check_single_page();
    tlb_addr_pkg::vtag_t t;
    t = fresh_4k_tag();
    write_page(t, rand_entry(), 1'b0);
    read_tag(t);
    read_tag(fresh_4k_tag());
    written_tags.push_back(t);
  endtask

  task automatic check_gigapage();
    logic [tlb_addr_pkg::page_idx_width-1:0] vpn;
    vpn = rand_giga_vpn();
    write_page({vpn, rand_low()}, rand_entry(), 1'b1);
    repeat (16)
      read_tag({vpn, rand_low()});
    written_tags.push_back({vpn, rand_low()});
  endtask

  task automatic check_replacement();
    tlb_addr_pkg::vtag_t tags[$];
    flush_stores();
    for (int i = 0; i < tlb_cfg_pkg::els_4k + 1; i++)
      tags.push_back(fresh_4k_tag());
    for (int i = 0; i < tlb_cfg_pkg::els_4k; i++)
      write_page(tags[i], rand_entry(), 1'b0);
    for (int i = 0; i < tlb_cfg_pkg::els_4k; i++)
      read_tag(tags[i]);
    write_page(tags[tlb_cfg_pkg::els_4k], rand_entry(), 1'b0);
    hit_count = 0;
    counting  = 1'b1;
    foreach (tags[i])
      read_tag(tags[i]);
    counting = 1'b0;
    check_hit_count(tlb_cfg_pkg::els_4k);
    foreach (tags[i])
      written_tags.push_back(tags[i]);
  endtask

  task automatic check_flush();
    flush_stores();
    foreach (written_tags[i])
      read_tag(written_tags[i]);
  endtask

  task automatic check_multi_hit();
    logic [tlb_addr_pkg::page_idx_width-1:0] vpn;
    tlb_addr_pkg::vtag_t shared;
    tlb_addr_pkg::vtag_t other_a;
    tlb_addr_pkg::vtag_t other_b;
    vpn    = rand_giga_vpn();
    shared = {vpn, rand_low()};
    other_a = fresh_4k_tag();
    write_page(other_a, rand_entry(), 1'b0);
    other_b = fresh_4k_tag();
    write_page(other_b, rand_entry(), 1'b0);
    write_page(shared, rand_entry(), 1'b0);
    write_page({vpn, rand_low()}, rand_entry(), 1'b1);
    read_tag(shared);
    read_tag(shared);
    read_tag(other_a);
    read_tag(other_b);
  endtask

  initial
    begin
      void'($urandom(32'h7e8a7013));
      reset_i    = 1'b1;
      flush_i    = 1'b0;
      v_i        = 1'b0;
      w_i        = 1'b0;
      gigapage_i = 1'b0;
      vtag_i     = '0;
      entry_i    = '0;
      req_chk    = 1'b0;
      req_known  = 1'b0;
      req_v      = 1'b0;
      req_entry  = '0;
      counting   = 1'b0;
      hit_count  = 0;
      count_chk  = 1'b0;
      count_exp  = 0;
      repeat (8) @(negedge clk_i);
      reset_i = 1'b0;
      repeat (20)
        read_tag(tlb_addr_pkg::vtag_t'($urandom));
      for (int r = 0; r < rounds; r++)
        begin
          written_tags.delete();
          flush_stores();
          check_single_page();
          check_gigapage();
          check_replacement();
          check_flush();
          check_multi_hit();
        end
      repeat (3) idle_cycle();
      $display("All tests passed");
      $finish;
    end

endmodule

// ==== filelist.f ====
common/tlb_addr_pkg.sv
common/tlb_cfg_pkg.sv
common/tlb_lookup_if.sv
tlb_array/tlb_tag_cam.sv
tlb_array/tlb_repl.sv
tlb_array/tlb_page_store.sv
hw/tlb_req_decode.sv
hw/tlb_entry_mux.sv
hw/tlb_top.sv
testbench/tlb_tb.sv

// ==== Makefile ====
SIM      ?= verilator
TOP      := tlb_tb
FILELIST := filelist.f
SIMFLAGS := --binary --timing --assert -Wno-fatal --top-module $(TOP)
OBJ_DIR  := obj_dir
BIN      := $(OBJ_DIR)/V$(TOP)
LOG      := sim.log
SRCS     := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(SIMFLAGS) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "All tests passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
